/* sources.f */
+incdir+hdl
+incdir+tests
hdl/frontEndPkg.sv
hdl/icache.sv
hdl/fetchUnit.sv
hdl/fetchQueue.sv
hdl/instrDecode.sv
hdl/frontEnd.sv
tests/frontEndTb.sv

/* tests/frontEndTbTable.svh */
`ifndef FRONT_END_TB_TABLE_SVH
`define FRONT_END_TB_TABLE_SVH

    // One row per decoded output in order: pc, class, rd, rs1, imm
    typedef struct packed {
        t_pc pc;
        t_instrClass iclass;
        t_reg rd;
        t_reg rs1;
        t_word imm;
    } t_expRow;

    localparam int NUM_ROWS = 23;
    localparam int NUM_REDIRECTS = 2;

    t_expRow expRows [NUM_ROWS];
    int redirectStep [NUM_REDIRECTS]; // Row that the redirect comes before
    t_pc redirectTarget [NUM_REDIRECTS];

    task automatic loadTable();
        // From PC 0, the XOR clears then the first constant
        expRows[0] = '{32'h00, ALU_REG, 5'd1, 5'd1, 32'h0};
        expRows[1] = '{32'h04, ALU_REG, 5'd2, 5'd2, 32'h0};
        expRows[2] = '{32'h08, ALU_REG, 5'd3, 5'd3, 32'h0};
        expRows[3] = '{32'h0c, ALU_REG, 5'd4, 5'd4, 32'h0};
        expRows[4] = '{32'h10, ALU_REG, 5'd5, 5'd5, 32'h0};
        expRows[5] = '{32'h14, ALU_IMM, 5'd1, 5'd1, 32'h0de};
        expRows[6] = '{32'h18, SHIFT_IMM, 5'd1, 5'd1, 32'h8};
        expRows[7] = '{32'h1c, ALU_IMM, 5'd1, 5'd1, 32'h0ad};
        // Mid-stream jump into the shift and compare block
        expRows[8] = '{32'h4c, ALU_IMM, 5'd17, 5'd0, 32'h654};
        expRows[9] = '{32'h50, ALU_IMM, 5'd18, 5'd17, 32'hffff_ffff}; // 12'hfff sign-extends
        expRows[10] = '{32'h54, SHIFT_IMM, 5'd20, 5'd18, 32'h1}; // SRAI, funct7 stays out
        expRows[11] = '{32'h58, SHIFT_IMM, 5'd21, 5'd18, 32'h1};
        expRows[12] = '{32'h5c, ALU_REG, 5'd22, 5'd20, 32'h0};
        expRows[13] = '{32'h60, SHIFT_IMM, 5'd23, 5'd18, 32'h1f};
        expRows[14] = '{32'h64, ALU_REG, 5'd12, 5'd20, 32'h0};
        expRows[15] = '{32'h68, ALU_REG, 5'd13, 5'd20, 32'h0};
        expRows[16] = '{32'h6c, ALU_REG, 5'd3, 5'd1, 32'h0};
        expRows[17] = '{32'h70, ALU_REG, 5'd4, 5'd3, 32'h0};
        expRows[18] = '{32'h74, ALU_IMM, 5'd0, 5'd0, 32'h666};
        expRows[19] = '{32'h78, HALT, 5'd0, 5'd0, 32'h0};
        // Restart at the constant-building block after HALT
        expRows[20] = '{32'h14, ALU_IMM, 5'd1, 5'd1, 32'h0de};
        expRows[21] = '{32'h18, SHIFT_IMM, 5'd1, 5'd1, 32'h8};
        expRows[22] = '{32'h1c, ALU_IMM, 5'd1, 5'd1, 32'h0ad};

        redirectStep[0] = 8;
        redirectTarget[0] = 32'h4c;
        redirectStep[1] = 20;
        redirectTarget[1] = 32'h14;
    endtask

`endif

/* tests/frontEndTb.sv */
`timescale 1ns/10ps

module frontEndTb;
    import frontEndPkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int HALT_WATCH = 10; // Quiet cycles expected after HALT

    `include "frontEndTbTable.svh"

    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + RESET_CYCLES;

    logic clk;
    logic reset;
    logic redirectValid;
    t_pc redirectPc;
    logic redirectReady;
    logic outValid;
    t_decoded outData;
    logic outReady;
    logic halted;
    int errors;
    int checks;

    frontEnd frontEnd_inst (
        .clk(clk),
        .reset(reset),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .redirectReady(redirectReady),
        .outValid(outValid),
        .outData(outData),
        .outReady(outReady),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Returns at the falling edge before the edge that completes the transfer
    task automatic takeOutput(output t_decoded got);
        logic done;
        done = 1'b0;
        while (!done) begin
            nextCycle();
            outReady = ($urandom % 4) != 0;
            @(negedge clk);
            if (outValid && outReady) begin
                got = outData;
                done = 1'b1;
            end
        end
    endtask

    task automatic issueRedirect(input t_pc target);
        nextCycle();
        outReady = 1'b0; // Old output must not leave in the redirect cycle
        redirectValid = 1'b1;
        redirectPc = target;
        @(negedge clk);
        checkValue("redirectReady", 32'(redirectReady), 32'h1); // Ready whenever out of reset
        while (!redirectReady) begin
            @(negedge clk);
        end
        nextCycle();
        redirectValid = 1'b0;
        @(negedge clk);
        checkValue("halted", 32'(halted), 32'h0);
    endtask

    task automatic watchHalted();
        repeat (HALT_WATCH) begin
            nextCycle();
            outReady = ($urandom % 2) != 0;
            @(negedge clk);
            checkValue("halted", 32'(halted), 32'h1);
            checkValue("outValid", 32'(outValid), 32'h0);
        end
    endtask

    task automatic compareRow(input int row, input t_decoded got);
        string tag;
        tag = $sformatf("row %0d outData.", row);
        checkValue({tag, "pc"}, got.pc, expRows[row].pc);
        checkValue({tag, "iclass"}, 32'(got.iclass), 32'(expRows[row].iclass));
        checkValue({tag, "rd"}, 32'(got.rd), 32'(expRows[row].rd));
        checkValue({tag, "rs1"}, 32'(got.rs1), 32'(expRows[row].rs1));
        checkValue({tag, "imm"}, got.imm, expRows[row].imm);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT gave no result within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        t_decoded got;
        int nextRedirect;
        int unsigned seedValue;
        errors = 0;
        checks = 0;
        nextRedirect = 0;
        seedValue = $urandom(32'h2ec1);
        reset = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        outReady = 1'b0;
        loadTable();

        repeat (RESET_CYCLES) nextCycle();
        checkValue("outValid", 32'(outValid), 32'h0);
        checkValue("halted", 32'(halted), 32'h0);
        reset = 1'b0;

        for (int row = 0; row < NUM_ROWS; row++) begin
            if (nextRedirect < NUM_REDIRECTS && redirectStep[nextRedirect] == row) begin
                issueRedirect(redirectTarget[nextRedirect]);
                nextRedirect++;
            end
            takeOutput(got);
            compareRow(row, got);
            if (expRows[row].iclass == HALT) begin
                watchHalted(); // Fetch must stay stopped until a redirect
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hdl/frontEnd.sv */
`timescale 1ns/10ps
`include "vroom_macros.svh"

module frontEnd (
    input logic clk,
    input logic reset,
    input logic redirectValid,
    input frontEndPkg::t_pc redirectPc,
    output logic redirectReady,
    output logic outValid,
    output frontEndPkg::t_decoded outData,
    input logic outReady,
    output logic halted
);
    import frontEndPkg::*;

    t_memReq req;
    t_memRsp rsp;
    t_fetchEntry pushEntry;
    t_fetchEntry head;
    logic push;
    logic flush;
    logic haltSeen;
    logic headValid;
    logic headReady;
    logic [$clog2(`FQ_DEPTH+1)-1:0] queueCount;

    icache icache_inst (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp)
    );

    fetchUnit fetchUnit_inst (
        .clk(clk),
        .reset(reset),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .redirectReady(redirectReady),
        .haltSeen(haltSeen),
        .req(req),
        .rsp(rsp),
        .push(push),
        .entry(pushEntry),
        .flush(flush),
        .queueCount(queueCount),
        .halted(halted)
    );

    fetchQueue fetchQueue_inst (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .push(push),
        .entry(pushEntry),
        .headValid(headValid),
        .head(head),
        .headReady(headReady),
        .count(queueCount)
    );

    instrDecode instrDecode_inst (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .inValid(headValid),
        .inEntry(head),
        .inReady(headReady),
        .outValid(outValid),
        .outData(outData),
        .outReady(outReady),
        .haltSeen(haltSeen)
    );

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic inValid,
    input frontEndPkg::t_fetchEntry inEntry,
    output logic inReady,
    output logic outValid,
    output frontEndPkg::t_decoded outData,
    input logic outReady,
    output logic haltSeen
);
    import frontEndPkg::*;

    t_decoded dec;
    t_word instr;
    logic [6:0] funct7;
    logic holdingHalt;
    logic load;

    assign instr = inEntry.instr;
    assign funct7 = instr[31:25];

    always_comb begin
        dec.pc = inEntry.pc;
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = instr[14:12];
        dec.funct7b5 = instr[30];
        dec.imm = '0;
        dec.iclass = ILLEGAL;

        if (instr == HALT_WORD) begin
            dec.iclass = HALT;
        end else if (instr[6:0] == OPC_OP) begin
            if (funct7 == 7'b0000000) begin
                dec.iclass = ALU_REG;
            end else if (funct7 == 7'b0100000 &&
                         (dec.funct3 == 3'b000 || dec.funct3 == 3'b101)) begin
                dec.iclass = ALU_REG; // SUB, SRA
            end
        end else if (instr[6:0] == OPC_OPIMM) begin
            if (dec.funct3 == 3'b001 || dec.funct3 == 3'b101) begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && dec.funct3 == 3'b101)) begin
                    dec.iclass = SHIFT_IMM;
                    dec.imm = {27'd0, instr[24:20]}; // shamt only
                end
            end else begin
                dec.iclass = ALU_IMM;
                dec.imm = {{20{instr[31]}}, instr[31:20]};
            end
        end
    end

    // Nothing follows HALT until fetch is flushed
    assign holdingHalt = outValid && (outData.iclass == HALT);
    assign inReady = (!outValid || outReady) && !holdingHalt;
    assign load = inValid && inReady;
    assign haltSeen = holdingHalt && outReady;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outData <= dec;
        end
    end

endmodule

/* hdl/fetchQueue.sv */
`timescale 1ns/10ps
`include "vroom_macros.svh"

module fetchQueue (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic push,
    input frontEndPkg::t_fetchEntry entry,
    output logic headValid,
    output frontEndPkg::t_fetchEntry head,
    input logic headReady,
    output logic [$clog2(`FQ_DEPTH+1)-1:0] count
);
    import frontEndPkg::*;

    localparam int PTR_W = $clog2(`FQ_DEPTH);
    localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

    t_fetchEntry mem [`FQ_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic pop;

    function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign headValid = (count != '0);
    assign head = mem[rdPtr];
    assign pop = headValid && headReady;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= entry;
        end
    end

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/10ps
`include "vroom_macros.svh"

module fetchUnit (
    input logic clk,
    input logic reset,
    input logic redirectValid,
    input frontEndPkg::t_pc redirectPc,
    output logic redirectReady,
    input logic haltSeen,
    output frontEndPkg::t_memReq req,
    input frontEndPkg::t_memRsp rsp,
    output logic push,
    output frontEndPkg::t_fetchEntry entry,
    output logic flush,
    input logic [$clog2(`FQ_DEPTH+1)-1:0] queueCount,
    output logic halted
);
    import frontEndPkg::*;

    localparam int CNT_W = $clog2(`FQ_DEPTH + 1);
    localparam int SEQ_W = `FE_ID_W - 1;

    typedef enum logic {
        RUNNING,
        STOPPED
    } t_fetchState;

    t_fetchState state;
    t_pc fetchPc;
    logic epoch;
    logic [SEQ_W-1:0] seq;
    logic started; // Low during reset and the cycle after
    logic redirectFire;
    logic [CNT_W:0] credits;
    logic rspFresh;

    t_pc pcTable [2**SEQ_W]; // PC of each in-flight id

    assign redirectReady = started;
    assign redirectFire = redirectValid && started;
    assign flush = redirectFire || haltSeen;
    assign halted = (state == STOPPED);

    // A response this cycle is already owed a queue slot
    assign credits = (CNT_W+1)'(`FQ_DEPTH) - ({1'b0, queueCount} + (CNT_W+1)'(rsp.valid));

    always_comb begin
        req.valid = started && (state == RUNNING) && !flush && (credits != '0);
        req.id = {epoch, seq};
        req.addr = fetchPc;
    end

    assign rspFresh = rsp.valid && (rsp.id[`FE_ID_W-1] == epoch);
    assign push = rspFresh && !flush;
    assign entry.pc = pcTable[rsp.id[SEQ_W-1:0]];
    assign entry.instr = rsp.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUNNING;
            fetchPc <= '0;
            epoch <= 1'b0;
            seq <= '0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (redirectFire) begin
                state <= RUNNING;
                fetchPc <= redirectPc;
                epoch <= ~epoch; // Anything still in flight goes stale
            end else if (haltSeen) begin
                state <= STOPPED;
                epoch <= ~epoch;
            end else if (req.valid) begin
                fetchPc <= fetchPc + 32'd4;
                seq <= seq + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            pcTable[seq] <= fetchPc;
        end
    end

endmodule

/* hdl/icache.sv */
`timescale 1ns/10ps
`include "vroom_macros.svh"

module icache (
    input logic clk,
    input logic reset,
    input frontEndPkg::t_memReq req,
    output frontEndPkg::t_memRsp rsp
);
    import frontEndPkg::*;

    localparam int IDX_W = $clog2(`IROM_DEPTH);

    t_word rom [`IROM_DEPTH];

    logic [IDX_W-1:0] idx;

    assign idx = req.addr[IDX_W+1:2]; // Word index

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
        end
        rsp.id <= req.id;
        rsp.data <= rom[idx];
    end

    initial begin
        int a;
        a = 0;
        for (int i = 0; i < `IROM_DEPTH; i++) begin
            rom[i] = rvSUB(0, 0, 0);
        end

        // Clear x1..x5
        rom[a++] = rvXOR(1, 1, 1);
        rom[a++] = rvXOR(2, 2, 2);
        rom[a++] = rvXOR(3, 3, 3);
        rom[a++] = rvXOR(4, 4, 4);
        rom[a++] = rvXOR(5, 5, 5);

        // Build 0xdeadbeef in x1 a byte at a time
        rom[a++] = rvADDI(1, 1, 12'hde);
        rom[a++] = rvSLLI(1, 1, 5'd8);
        rom[a++] = rvADDI(1, 1, 12'had);
        rom[a++] = rvSLLI(1, 1, 5'd8);
        rom[a++] = rvADDI(1, 1, 12'hbe);
        rom[a++] = rvSLLI(1, 1, 5'd8);
        rom[a++] = rvADDI(1, 1, 12'hef);

        // And 0xcafebabe in x2
        rom[a++] = rvADDI(2, 2, 12'hca);
        rom[a++] = rvSLLI(2, 2, 5'd8);
        rom[a++] = rvADDI(2, 2, 12'hfe);
        rom[a++] = rvSLLI(2, 2, 5'd8);
        rom[a++] = rvADDI(2, 2, 12'hba);
        rom[a++] = rvSLLI(2, 2, 5'd8);
        rom[a++] = rvADDI(2, 2, 12'hbe);

        // Shifts and compares on a negative value
        rom[a++] = rvADDI(17, 0, 12'h654);
        rom[a++] = rvXORI(18, 17, 12'hfff);
        rom[a++] = rvSRAI(20, 18, 5'h1);
        rom[a++] = rvSRLI(21, 18, 5'h1);
        rom[a++] = rvXOR(22, 20, 21);
        rom[a++] = rvSLLI(23, 18, 5'd31);
        rom[a++] = rvSLT(12, 20, 21);
        rom[a++] = rvSLTU(13, 20, 21);
        rom[a++] = rvADD(3, 1, 2);
        rom[a++] = rvSUB(4, 3, 1);

        rom[a++] = rvADDI(0, 0, 12'h666); // End of test marker
        rom[a++] = rvHALT();
    end

endmodule

/* hdl/frontEndPkg.sv */
`include "vroom_macros.svh"

package frontEndPkg;

    typedef logic [31:0] t_word;
    typedef logic [31:0] t_pc;
    typedef logic [4:0] t_reg;
    typedef logic [`FE_ID_W-1:0] t_feId;

    typedef struct packed {
        logic valid;
        t_feId id;
        t_pc addr;
    } t_memReq;

    typedef struct packed {
        logic valid;
        t_feId id;
        t_word data;
    } t_memRsp;

    typedef struct packed {
        t_pc pc;
        t_word instr;
    } t_fetchEntry;

    typedef enum logic [2:0] {
        ALU_REG,
        ALU_IMM,
        SHIFT_IMM,
        HALT,
        ILLEGAL
    } t_instrClass;

    typedef struct packed {
        t_pc pc;
        t_instrClass iclass;
        t_reg rd;
        t_reg rs1;
        t_reg rs2;
        logic [2:0] funct3;
        logic funct7b5; // Selects SUB and SRA/SRAI
        t_word imm;
    } t_decoded;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    // ecall
    localparam t_word HALT_WORD = 32'h0000_0073;

    function automatic t_word rvRType(logic [6:0] f7, t_reg rs2, t_reg rs1,
                                      logic [2:0] f3, t_reg rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic t_word rvIType(logic [11:0] imm, t_reg rs1, logic [2:0] f3, t_reg rd);
        return {imm, rs1, f3, rd, OPC_OPIMM};
    endfunction

    function automatic t_word rvADD(t_reg rd, t_reg rs1, t_reg rs2);
        return rvRType(7'b0000000, rs2, rs1, 3'b000, rd);
    endfunction

    function automatic t_word rvSUB(t_reg rd, t_reg rs1, t_reg rs2);
        return rvRType(7'b0100000, rs2, rs1, 3'b000, rd);
    endfunction

    function automatic t_word rvXOR(t_reg rd, t_reg rs1, t_reg rs2);
        return rvRType(7'b0000000, rs2, rs1, 3'b100, rd);
    endfunction

    function automatic t_word rvSLT(t_reg rd, t_reg rs1, t_reg rs2);
        return rvRType(7'b0000000, rs2, rs1, 3'b010, rd);
    endfunction

    function automatic t_word rvSLTU(t_reg rd, t_reg rs1, t_reg rs2);
        return rvRType(7'b0000000, rs2, rs1, 3'b011, rd);
    endfunction

    function automatic t_word rvADDI(t_reg rd, t_reg rs1, logic [11:0] imm);
        return rvIType(imm, rs1, 3'b000, rd);
    endfunction

    function automatic t_word rvXORI(t_reg rd, t_reg rs1, logic [11:0] imm);
        return rvIType(imm, rs1, 3'b100, rd);
    endfunction

    // Shifts reuse the R-type layout with shamt in the rs2 slot
    function automatic t_word rvSLLI(t_reg rd, t_reg rs1, logic [4:0] shamt);
        return {7'b0000000, shamt, rs1, 3'b001, rd, OPC_OPIMM};
    endfunction

    function automatic t_word rvSRLI(t_reg rd, t_reg rs1, logic [4:0] shamt);
        return {7'b0000000, shamt, rs1, 3'b101, rd, OPC_OPIMM};
    endfunction

    function automatic t_word rvSRAI(t_reg rd, t_reg rs1, logic [4:0] shamt);
        return {7'b0100000, shamt, rs1, 3'b101, rd, OPC_OPIMM};
    endfunction

    function automatic t_word rvHALT();
        return HALT_WORD;
    endfunction

endpackage

/* hdl/vroom_macros.svh */
`ifndef VROOM_MACROS_SVH
`define VROOM_MACROS_SVH

// Instruction ROM size in 32-bit words
`define IROM_DEPTH 128

// Fetch queue entries
`define FQ_DEPTH 4

// Request tag, top bit is the epoch
`define FE_ID_W 4

`endif
